//--- src/sb_isa_pkg.sv
// integer registers only; register 0 is hardwired and fu_t NONE must stay encoded as zero
`default_nettype none

package sb_isa_pkg;

  // ----------------------------------------
  // data path widths
  // ----------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // register file depth follows from the address width
  localparam int unsigned NR_REGS    = 2 ** REG_ADDR_W;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]       data_t;

  // ----------------------------------------
  // functional units
  // ----------------------------------------
  // NONE completes without write-back and marks a free register in the clobber map
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5,
    CSR    = 3'd6
  } fu_t;

endpackage

`default_nettype wire

//--- src/sb_cfg_pkg.sv
// defaults only; the entry count must be a power of two for the id width rule to hold
`default_nettype none

package sb_cfg_pkg;

  // ----------------------------------------
  // scoreboard size defaults
  // ----------------------------------------
  // queue depth, power of two
  localparam int unsigned DEFAULT_NR_ENTRIES  = 8;
  // result buses from the functional units
  localparam int unsigned DEFAULT_NR_WB_PORTS = 2;

  // ----------------------------------------
  // transaction id width
  // ----------------------------------------
  // the id is the queue slot, so it needs log2 of the depth
  // a single-entry queue still gets a one bit id
  function automatic int unsigned trans_id_w(input int unsigned nr_entries);
    if (nr_entries > 1) begin
      return $clog2(nr_entries);
    end
    return 1;
  endfunction

endpackage

`default_nettype wire

//--- src/sb_entry_view_if.sv
// read-only window onto the queue state; clock and reset only serve checks on the consumer side
`timescale 1ns/1ps
`default_nettype none

interface sb_entry_view_if #(
  parameter int unsigned NrEntries = 8
) (
  input logic clk_i,
  input logic rst_ni
);

  // one element per queue slot
  logic                                   [NrEntries-1:0] issued;
  logic                                   [NrEntries-1:0] done;
  sb_isa_pkg::reg_addr_t [NrEntries-1:0]                  rd;
  sb_isa_pkg::fu_t       [NrEntries-1:0]                  fu;
  sb_isa_pkg::data_t     [NrEntries-1:0]                  result;

  // the queue owns the state
  modport producer (
    output issued, done, rd, fu, result
  );

  // clobber and forwarding logic look but never touch
  modport consumer (
    input clk_i, rst_ni,
    input issued, done, rd, fu, result
  );

endinterface

`default_nettype wire

//--- src/sb_prio_pick.sv
// combinational only; with no request the output is the all-zero payload, which is NONE for fu_t
`timescale 1ns/1ps
`default_nettype none

module sb_prio_pick #(
  parameter int unsigned NumIn     = 2,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     [NumIn-1:0] req_i,
  input  payload_t [NumIn-1:0] data_i,
  output logic                 valid_o,
  output payload_t             data_o
);

  assign valid_o = |req_i;

  // walk from the top so the lowest index lands last and wins
  always_comb begin
    data_o = payload_t'('0);
    for (int i = NumIn - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o = data_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sb_issue_queue.sv
// NrEntries must be a power of two; one commit per cycle, and commit_ack_i only while commit_valid_o
`timescale 1ns/1ps
`default_nettype none

module sb_issue_queue #(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   unresolved_branch_i,
  // decode side
  input  logic                                   decoded_valid_i,
  input  sb_isa_pkg::reg_addr_t                  decoded_rd_i,
  input  sb_isa_pkg::fu_t                        decoded_fu_i,
  input  logic                                   issue_ack_i,
  output logic                                   issue_valid_o,
  output logic                                   decoded_ack_o,
  output logic [sb_cfg_pkg::trans_id_w(NrEntries)-1:0] issue_trans_id_o,
  output logic                                   sb_full_o,
  // write-back ports
  input  logic [NrWbPorts-1:0]                   wb_valid_i,
  input  logic [NrWbPorts-1:0][sb_cfg_pkg::trans_id_w(NrEntries)-1:0] wb_trans_id_i,
  input  sb_isa_pkg::data_t [NrWbPorts-1:0]      wb_data_i,
  // commit port
  input  logic                                   commit_ack_i,
  output logic                                   commit_valid_o,
  output sb_isa_pkg::reg_addr_t                  commit_rd_o,
  output sb_isa_pkg::fu_t                        commit_fu_o,
  output sb_isa_pkg::data_t                      commit_result_o,
  output logic [sb_cfg_pkg::trans_id_w(NrEntries)-1:0] commit_trans_id_o,
  sb_entry_view_if.producer                      view
);

  localparam int unsigned IdxW = sb_cfg_pkg::trans_id_w(NrEntries);

  typedef logic [IdxW-1:0] idx_t;
  // one extra bit so that a full queue differs from an empty one
  typedef logic [IdxW:0]   cnt_t;

  logic [NrEntries-1:0]  issued_q, issued_d;
  logic [NrEntries-1:0]  done_q, done_d;
  sb_isa_pkg::reg_addr_t [NrEntries-1:0] rd_q;
  sb_isa_pkg::fu_t       [NrEntries-1:0] fu_q;
  sb_isa_pkg::data_t     [NrEntries-1:0] result_q;
  idx_t                  issue_ptr_q, commit_ptr_q;
  cnt_t                  cnt_q;
  logic                  full;
  logic                  issue_en;

  // ----------------------------------------
  // issue handshake
  // ----------------------------------------
  // top count bit is set only with all slots taken
  assign full             = cnt_q[IdxW];
  assign sb_full_o        = full;
  assign issue_valid_o    = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o    = issue_ack_i & ~full;
  assign issue_trans_id_o = issue_ptr_q;
  // flush drops the instruction offered in the same cycle
  assign issue_en         = decoded_valid_i & decoded_ack_o & ~flush_i;

  // ----------------------------------------
  // entry state update
  // ----------------------------------------
  always_comb begin
    issued_d = issued_q;
    done_d   = done_q;
    if (issue_en) begin
      issued_d[issue_ptr_q] = 1'b1;
    end
    // no unit to wait for, done one cycle after storing
    for (int unsigned i = 0; i < NrEntries; i++) begin
      if (issued_q[i] && (fu_q[i] == sb_isa_pkg::NONE)) begin
        done_d[i] = 1'b1;
      end
    end
    // results for dead slots are late returns after a flush
    for (int unsigned k = 0; k < NrWbPorts; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        done_d[wb_trans_id_i[k]] = 1'b1;
      end
    end
    if (commit_ack_i) begin
      issued_d[commit_ptr_q] = 1'b0;
      done_d[commit_ptr_q]   = 1'b0;
    end
    if (flush_i) begin
      issued_d = '0;
      done_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      done_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      issued_q     <= issued_d;
      done_q       <= done_d;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      done_q       <= done_d;
      // pointers wrap on their own, depth is a power of two
      issue_ptr_q  <= issue_ptr_q + idx_t'(issue_en);
      commit_ptr_q <= commit_ptr_q + idx_t'(commit_ack_i);
      cnt_q        <= cnt_q + cnt_t'(issue_en) - cnt_t'(commit_ack_i);
    end
  end

  // payload, qualified by issued and done
  always_ff @(posedge clk_i) begin
    if (issue_en) begin
      rd_q[issue_ptr_q] <= decoded_rd_i;
      fu_q[issue_ptr_q] <= decoded_fu_i;
    end
    for (int unsigned k = 0; k < NrWbPorts; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        result_q[wb_trans_id_i[k]] <= wb_data_i[k];
      end
    end
  end

  // ----------------------------------------
  // commit head and entry view
  // ----------------------------------------
  assign commit_valid_o    = issued_q[commit_ptr_q] & done_q[commit_ptr_q];
  assign commit_rd_o       = rd_q[commit_ptr_q];
  assign commit_fu_o       = fu_q[commit_ptr_q];
  assign commit_result_o   = result_q[commit_ptr_q];
  assign commit_trans_id_o = commit_ptr_q;

  assign view.issued = issued_q;
  assign view.done   = done_q;
  assign view.rd     = rd_q;
  assign view.fu     = fu_q;
  assign view.result = result_q;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  if (NrEntries != (2 ** IdxW)) begin : gen_size_check
    $fatal(1, "scoreboard depth must be a power of two");
  end

  // commit stage may only retire a finished head
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_valid_o)
    else $error("commit acknowledged without a committable head");

  // issue stage acks only what the scoreboard offered
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue acknowledged without a valid instruction");

  // two units never return the same slot together
  for (genvar i = 0; i < NrWbPorts; i++) begin : gen_wb_chk
    for (genvar j = i + 1; j < NrWbPorts; j++) begin : gen_pair
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_valid_i[i] && wb_valid_i[j]) |-> (wb_trans_id_i[i] != wb_trans_id_i[j]))
        else $error("write-back ports %0d and %0d share a transaction id", i, j);
    end
  end

endmodule

`default_nettype wire

//--- src/sb_clobber_map.sv
// assumes one live writer per register; with several, the lowest slot index is reported
`timescale 1ns/1ps
`default_nettype none

module sb_clobber_map #(
  parameter int unsigned NrEntries = 8
) (
  sb_entry_view_if.consumer                          view,
  output sb_isa_pkg::fu_t [sb_isa_pkg::NR_REGS-1:0] rd_clobber_o
);

  // x0 is never written
  assign rd_clobber_o[0] = sb_isa_pkg::NONE;

  // ----------------------------------------
  // per-register lookup
  // ----------------------------------------
  for (genvar r = 1; r < sb_isa_pkg::NR_REGS; r++) begin : gen_reg
    logic [NrEntries-1:0] req;
    logic                 hit;
    sb_isa_pkg::fu_t      pick;

    // every live entry aiming at this register
    for (genvar e = 0; e < NrEntries; e++) begin : gen_req
      assign req[e] = view.issued[e] && (view.rd[e] == sb_isa_pkg::reg_addr_t'(r));
    end

    sb_prio_pick #(
      .NumIn     (NrEntries),
      .payload_t (sb_isa_pkg::fu_t)
    ) u_pick (
      .req_i   (req),
      .data_i  (view.fu),
      .valid_o (hit),
      .data_o  (pick)
    );

    assign rd_clobber_o[r] = hit ? pick : sb_isa_pkg::NONE;
  end

endmodule

`default_nettype wire

//--- src/sb_operand_fwd.sv
// write-back data is taken at face value; stale ids after a flush must not reach the ports
`timescale 1ns/1ps
`default_nettype none

module sb_operand_fwd #(
  parameter int unsigned NrEntries = 8,
  parameter int unsigned NrWbPorts = 2
) (
  sb_entry_view_if.consumer                 view,
  input  logic [NrWbPorts-1:0]              wb_valid_i,
  input  logic [NrWbPorts-1:0][sb_cfg_pkg::trans_id_w(NrEntries)-1:0] wb_trans_id_i,
  input  sb_isa_pkg::data_t [NrWbPorts-1:0] wb_data_i,
  input  sb_isa_pkg::reg_addr_t             rs1_i,
  input  sb_isa_pkg::reg_addr_t             rs2_i,
  output sb_isa_pkg::data_t                 rs1_o,
  output logic                              rs1_valid_o,
  output sb_isa_pkg::data_t                 rs2_o,
  output logic                              rs2_valid_o
);

  // index 0 is rs1, index 1 is rs2
  sb_isa_pkg::reg_addr_t [1:0] rs_addr;
  sb_isa_pkg::data_t     [1:0] rs_data;
  logic                  [1:0] rs_valid;

  assign rs_addr = {rs2_i, rs1_i};

  // ----------------------------------------
  // per-source forwarding
  // ----------------------------------------
  for (genvar s = 0; s < 2; s++) begin : gen_src
    logic [NrWbPorts-1:0] wb_req;
    logic [NrEntries-1:0] ent_req;
    logic                 wb_hit, ent_hit;
    sb_isa_pkg::data_t    wb_val, ent_val;

    // result on a bus right now, rd looked up through its slot
    for (genvar k = 0; k < NrWbPorts; k++) begin : gen_wb_req
      assign wb_req[k] = wb_valid_i[k] && (view.rd[wb_trans_id_i[k]] == rs_addr[s]);
    end

    // result already parked in the queue
    for (genvar e = 0; e < NrEntries; e++) begin : gen_ent_req
      assign ent_req[e] = view.issued[e] && view.done[e] && (view.rd[e] == rs_addr[s]);
    end

    sb_prio_pick #(
      .NumIn     (NrWbPorts),
      .payload_t (sb_isa_pkg::data_t)
    ) u_wb_pick (
      .req_i   (wb_req),
      .data_i  (wb_data_i),
      .valid_o (wb_hit),
      .data_o  (wb_val)
    );

    sb_prio_pick #(
      .NumIn     (NrEntries),
      .payload_t (sb_isa_pkg::data_t)
    ) u_ent_pick (
      .req_i   (ent_req),
      .data_i  (view.result),
      .valid_o (ent_hit),
      .data_o  (ent_val)
    );

    // the bus is newer than anything stored
    assign rs_data[s]  = wb_hit ? wb_val : ent_val;
    // x0 reads come from the register file
    assign rs_valid[s] = (wb_hit || ent_hit) && (rs_addr[s] != '0);
  end

  assign rs1_o       = rs_data[0];
  assign rs1_valid_o = rs_valid[0];
  assign rs2_o       = rs_data[1];
  assign rs2_valid_o = rs_valid[1];

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // a bus naming a free slot would forward a stale rd match
  for (genvar k = 0; k < NrWbPorts; k++) begin : gen_wb_chk
    assert property (@(posedge view.clk_i) disable iff (!view.rst_ni)
      wb_valid_i[k] |-> view.issued[wb_trans_id_i[k]])
      else $error("write-back port %0d names a free slot", k);
  end

endmodule

`default_nettype wire

//--- src/scoreboard.sv
// NrEntries a power of two, NrWbPorts at least one; single in-order commit port
`timescale 1ns/1ps
`default_nettype none

module scoreboard #(
  parameter int unsigned NrEntries = sb_cfg_pkg::DEFAULT_NR_ENTRIES,
  parameter int unsigned NrWbPorts = sb_cfg_pkg::DEFAULT_NR_WB_PORTS
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   unresolved_branch_i,
  // decode and issue
  input  logic                                   decoded_valid_i,
  input  sb_isa_pkg::reg_addr_t                  decoded_rd_i,
  input  sb_isa_pkg::fu_t                        decoded_fu_i,
  input  logic                                   issue_ack_i,
  output logic                                   issue_valid_o,
  output logic                                   decoded_ack_o,
  output logic                                   sb_full_o,
  output logic [sb_cfg_pkg::trans_id_w(NrEntries)-1:0] issue_trans_id_o,
  // write-back
  input  logic [NrWbPorts-1:0]                   wb_valid_i,
  input  logic [NrWbPorts-1:0][sb_cfg_pkg::trans_id_w(NrEntries)-1:0] wb_trans_id_i,
  input  sb_isa_pkg::data_t [NrWbPorts-1:0]      wb_data_i,
  // commit
  input  logic                                   commit_ack_i,
  output logic                                   commit_valid_o,
  output sb_isa_pkg::reg_addr_t                  commit_rd_o,
  output sb_isa_pkg::fu_t                        commit_fu_o,
  output sb_isa_pkg::data_t                      commit_result_o,
  output logic [sb_cfg_pkg::trans_id_w(NrEntries)-1:0] commit_trans_id_o,
  // operand read
  input  sb_isa_pkg::reg_addr_t                  rs1_i,
  input  sb_isa_pkg::reg_addr_t                  rs2_i,
  output sb_isa_pkg::data_t                      rs1_o,
  output sb_isa_pkg::data_t                      rs2_o,
  output logic                                   rs1_valid_o,
  output logic                                   rs2_valid_o,
  output sb_isa_pkg::fu_t [sb_isa_pkg::NR_REGS-1:0] rd_clobber_o
);

  // queue state shared with the lookup blocks
  sb_entry_view_if #(.NrEntries(NrEntries)) view (.clk_i(clk_i), .rst_ni(rst_ni));

  sb_issue_queue #(
    .NrEntries (NrEntries),
    .NrWbPorts (NrWbPorts)
  ) u_queue (
    .clk_i, .rst_ni, .flush_i, .unresolved_branch_i,
    .decoded_valid_i, .decoded_rd_i, .decoded_fu_i,
    .issue_ack_i, .issue_valid_o, .decoded_ack_o, .issue_trans_id_o, .sb_full_o,
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .commit_ack_i, .commit_valid_o, .commit_rd_o, .commit_fu_o,
    .commit_result_o, .commit_trans_id_o,
    .view (view.producer)
  );

  sb_clobber_map #(
    .NrEntries (NrEntries)
  ) u_clobber (
    .view (view.consumer),
    .rd_clobber_o
  );

  sb_operand_fwd #(
    .NrEntries (NrEntries),
    .NrWbPorts (NrWbPorts)
  ) u_fwd (
    .view (view.consumer),
    .wb_valid_i, .wb_trans_id_i, .wb_data_i,
    .rs1_i, .rs2_i, .rs1_o, .rs1_valid_o, .rs2_o, .rs2_valid_o
  );

endmodule

`default_nettype wire

//--- testbench/tb_scoreboard.sv
// run from the project root; DUT uses the default depth of 8 and two write-back ports
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard;

  // ----------------------------------------
  // run constants
  // ----------------------------------------
  localparam int unsigned CLK_PERIOD_NS = 100;
  localparam int unsigned RST_CYCLES    = 10;
  // margin on top of trace and reset length
  localparam int unsigned SLACK_CYCLES  = 20;
  // 15 input columns then 11 expected columns
  localparam int unsigned NF            = 26;
  localparam string       TRACE_FILE    = "testbench/scoreboard_trace.txt";
  localparam int unsigned NWB           = sb_cfg_pkg::DEFAULT_NR_WB_PORTS;
  localparam int unsigned IDW = sb_cfg_pkg::trans_id_w(sb_cfg_pkg::DEFAULT_NR_ENTRIES);

  typedef logic [IDW-1:0] id_t;

  logic clk;
  logic rst_n;
  logic flush, unresolved_branch, decoded_valid, issue_ack, commit_ack;
  sb_isa_pkg::reg_addr_t decoded_rd, rs1, rs2, commit_rd;
  sb_isa_pkg::fu_t       decoded_fu, commit_fu;
  logic issue_valid, decoded_ack, sb_full, commit_valid, rs1_valid, rs2_valid;
  id_t  issue_trans_id, commit_trans_id;
  logic [NWB-1:0]              wb_valid;
  id_t  [NWB-1:0]              wb_trans_id;
  sb_isa_pkg::data_t [NWB-1:0] wb_data;
  sb_isa_pkg::data_t           commit_result, rs1_data, rs2_data;
  sb_isa_pkg::fu_t [sb_isa_pkg::NR_REGS-1:0] rd_clobber;

  // all trace columns, line after line
  logic [31:0]           trace_q [$];
  int unsigned           nr_lines;
  logic                  trace_loaded;
  sb_isa_pkg::reg_addr_t clobber_reg;

  // in-order slot bookkeeping from accepted issues and commits
  id_t             exp_issue_id;
  id_t             exp_commit_id;
  sb_isa_pkg::fu_t exp_fu [sb_cfg_pkg::DEFAULT_NR_ENTRIES];

  scoreboard #(
    .NrEntries (sb_cfg_pkg::DEFAULT_NR_ENTRIES),
    .NrWbPorts (NWB)
  ) dut (
    .clk_i (clk), .rst_ni (rst_n), .flush_i (flush),
    .unresolved_branch_i (unresolved_branch),
    .decoded_valid_i (decoded_valid), .decoded_rd_i (decoded_rd),
    .decoded_fu_i (decoded_fu), .issue_ack_i (issue_ack),
    .issue_valid_o (issue_valid), .decoded_ack_o (decoded_ack),
    .sb_full_o (sb_full), .issue_trans_id_o (issue_trans_id),
    .wb_valid_i (wb_valid), .wb_trans_id_i (wb_trans_id), .wb_data_i (wb_data),
    .commit_ack_i (commit_ack), .commit_valid_o (commit_valid),
    .commit_rd_o (commit_rd), .commit_fu_o (commit_fu),
    .commit_result_o (commit_result), .commit_trans_id_o (commit_trans_id),
    .rs1_i (rs1), .rs2_i (rs2), .rs1_o (rs1_data), .rs2_o (rs2_data),
    .rs1_valid_o (rs1_valid), .rs2_valid_o (rs2_valid),
    .rd_clobber_o (rd_clobber)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  function automatic logic [31:0] trace_field(input int unsigned n, input int unsigned f);
    return trace_q[n * NF + f];
  endfunction

  task automatic load_trace();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] w [NF];
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open trace file %s", TRACE_FILE));
    end else begin
      while ($fgets(line, fd) > 0) begin
        // comment and blank lines carry no cycle
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8], w[9], w[10], w[11],
            w[12], w[13], w[14], w[15], w[16], w[17], w[18], w[19], w[20], w[21],
            w[22], w[23], w[24], w[25]);
          if (cnt != NF) begin
            abort_run($sformatf("malformed trace line, %0d columns read: %s", cnt, line));
          end else begin
            foreach (w[i]) trace_q.push_back(w[i]);
          end
        end
      end
      $fclose(fd);
      nr_lines = trace_q.size() / NF;
      if (nr_lines == 0) abort_run("trace file holds no cycles");
    end
  endtask

  task automatic apply_inputs(input int unsigned n);
    flush             <= 1'(trace_field(n, 0));
    unresolved_branch <= 1'(trace_field(n, 1));
    decoded_valid     <= 1'(trace_field(n, 2));
    decoded_rd        <= sb_isa_pkg::reg_addr_t'(trace_field(n, 3));
    decoded_fu        <= sb_isa_pkg::fu_t'(3'(trace_field(n, 4)));
    issue_ack         <= 1'(trace_field(n, 5));
    wb_valid          <= 2'(trace_field(n, 6));
    // port 1 in the upper half
    wb_trans_id       <= {id_t'(trace_field(n, 9)), id_t'(trace_field(n, 7))};
    wb_data           <= {trace_field(n, 10), trace_field(n, 8)};
    commit_ack        <= 1'(trace_field(n, 11));
    rs1               <= sb_isa_pkg::reg_addr_t'(trace_field(n, 12));
    rs2               <= sb_isa_pkg::reg_addr_t'(trace_field(n, 13));
    // register whose clobber entry is watched this cycle
    clobber_reg        = sb_isa_pkg::reg_addr_t'(trace_field(n, 14));
  endtask

  // slots are handed out in order and a flush restarts both pointers
  task automatic track_slots(input int unsigned n);
    if (trace_field(n, 0) != 0) begin
      exp_issue_id  = '0;
      exp_commit_id = '0;
    end else begin
      if (trace_field(n, 2) != 0 && trace_field(n, 16) != 0) begin
        exp_fu[exp_issue_id] = sb_isa_pkg::fu_t'(3'(trace_field(n, 4)));
        exp_issue_id         = exp_issue_id + 1'b1;
      end
      if (trace_field(n, 11) != 0) begin
        exp_commit_id = exp_commit_id + 1'b1;
      end
    end
  endtask

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    assert (actual === expected) else begin
      abort_run($sformatf("** Error at %0d ns: %s expected %0h, actual %0h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic compare_outputs(input int unsigned n);
    expect_equal("issue_valid_o", 32'(issue_valid), trace_field(n, 15));
    expect_equal("decoded_ack_o", 32'(decoded_ack), trace_field(n, 16));
    expect_equal("issue_trans_id_o", 32'(issue_trans_id), 32'(exp_issue_id));
    expect_equal("sb_full_o", 32'(sb_full), trace_field(n, 17));
    expect_equal("commit_valid_o", 32'(commit_valid), trace_field(n, 18));
    // head payload only matters with a committable head
    if (trace_field(n, 18) != 0) begin
      expect_equal("commit_rd_o", 32'(commit_rd), trace_field(n, 19));
      expect_equal("commit_fu_o", 32'(commit_fu), 32'(exp_fu[exp_commit_id]));
      expect_equal("commit_trans_id_o", 32'(commit_trans_id), 32'(exp_commit_id));
      // a unit-less entry never receives a result
      if (exp_fu[exp_commit_id] != sb_isa_pkg::NONE) begin
        expect_equal("commit_result_o", commit_result, trace_field(n, 20));
      end
    end
    expect_equal("rs1_valid_o", 32'(rs1_valid), trace_field(n, 21));
    if (trace_field(n, 21) != 0) expect_equal("rs1_o", rs1_data, trace_field(n, 22));
    expect_equal("rs2_valid_o", 32'(rs2_valid), trace_field(n, 23));
    if (trace_field(n, 23) != 0) expect_equal("rs2_o", rs2_data, trace_field(n, 24));
    expect_equal($sformatf("rd_clobber_o[%0d]", clobber_reg),
                 32'(rd_clobber[clobber_reg]), trace_field(n, 25));
  endtask

  // ----------------------------------------
  // clock, stimulus and watchdog
  // ----------------------------------------
  initial clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  initial begin
    rst_n             = 1'b0;
    flush             = 1'b0;
    unresolved_branch = 1'b0;
    decoded_valid     = 1'b0;
    decoded_rd        = '0;
    decoded_fu        = sb_isa_pkg::NONE;
    issue_ack         = 1'b0;
    wb_valid          = '0;
    wb_trans_id       = '0;
    wb_data           = '0;
    commit_ack        = 1'b0;
    rs1               = '0;
    rs2               = '0;
    clobber_reg       = '0;
    exp_issue_id      = '0;
    exp_commit_id     = '0;
    trace_loaded      = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // drive on the rising edge, look on the falling edge
    for (int unsigned n = 0; n < nr_lines; n++) begin
      @(posedge clk);
      apply_inputs(n);
      @(negedge clk);
      compare_outputs(n);
      track_slots(n);
    end
    $display("Test passed");
    $finish;
  end

  initial begin
    wait (trace_loaded);
    #((nr_lines + RST_CYCLES + SLACK_CYCLES) * CLK_PERIOD_NS);
    abort_run("watchdog expired, the trace run did not finish in time");
  end

endmodule

`default_nettype wire

//--- testbench/scoreboard_trace.txt
# in (hex): flush ubranch dvalid rd fu iack wbvalid id0 data0 id1 data1 cack rs1 rs2 clobreg
# out (hex): ivalid dack full cvalid crd cresult rs1v rs1 rs2v rs2 clobfu; fu 0 NONE 1 ALU
0 0 1 05 1 1 0 0 0 0 0 0 00 00 05  1 1 0 0 00 0 0 0 0 0 0
0 0 0 00 0 0 1 0 cafe0005 0 0 0 05 00 05  0 0 0 0 00 0 1 cafe0005 0 0 1
0 0 0 00 0 0 0 0 0 0 0 1 00 05 05  0 0 0 1 05 cafe0005 0 0 1 cafe0005 1
0 0 0 00 0 0 0 0 0 0 0 0 00 00 05  0 0 0 0 00 0 0 0 0 0 0
0 0 1 0a 5 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 0
0 0 1 0b 1 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 0c 3 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 0d 4 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 0e 6 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 0f 2 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 10 1 1 0 0 0 0 0 0 00 00 0a  1 1 0 0 00 0 0 0 0 0 5
0 0 1 11 3 1 0 0 0 0 0 0 00 00 11  1 1 0 0 00 0 0 0 0 0 0
0 0 1 12 1 0 1 1 0000aaaa 0 0 0 0a 00 11  0 0 1 0 00 0 1 0000aaaa 0 0 3
0 0 1 12 1 0 2 0 0 2 0000bbbb 1 0b 0a 0a  0 0 1 1 0a 0000aaaa 1 0000bbbb 1 0000aaaa 5
0 0 1 12 1 1 0 0 0 0 0 0 00 00 0a  1 1 0 1 0b 0000bbbb 0 0 0 0 0
1 0 0 00 0 0 0 0 0 0 0 0 00 00 12  0 0 1 1 0b 0000bbbb 0 0 0 0 1
0 1 1 14 0 0 0 0 0 0 0 0 00 00 12  0 0 0 0 00 0 0 0 0 0 0
0 0 1 14 0 1 0 0 0 0 0 0 00 00 14  1 1 0 0 00 0 0 0 0 0 0
0 0 0 00 0 0 0 0 0 0 0 0 00 00 14  0 0 0 0 00 0 0 0 0 0 0
0 0 0 00 0 0 0 0 0 0 0 1 00 00 14  0 0 0 1 14 cafe0005 0 0 0 0 0
0 0 1 00 1 1 0 0 0 0 0 0 00 00 00  1 1 0 0 00 0 0 0 0 0 0
0 0 0 00 0 0 1 1 12345678 0 0 0 00 00 00  0 0 0 0 00 0 0 0 0 0 0
0 0 0 00 0 0 0 0 0 0 0 1 00 00 00  0 0 0 1 00 12345678 0 0 0 0 0
0 0 0 00 0 0 0 0 0 0 0 0 00 00 00  0 0 0 0 00 0 0 0 0 0 0

//--- sim.f
src/sb_isa_pkg.sv
src/sb_cfg_pkg.sv
src/sb_entry_view_if.sv
src/sb_prio_pick.sv
src/sb_issue_queue.sv
src/sb_clobber_map.sv
src/sb_operand_fwd.sv
src/scoreboard.sv
testbench/tb_scoreboard.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_scoreboard
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
